/* src/conv_feed_pkg.sv */
package conv_feed_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int PIX_W        = 8;
    localparam int PIX_PER_WORD = 8;
    localparam int SRAM_W       = PIX_W * PIX_PER_WORD;
    localparam int WIN_ROWS     = 3;
    localparam int TAPS         = WIN_ROWS * WIN_ROWS;
    localparam int DIM_W        = 8;
    localparam int COL_W        = $clog2(PIX_PER_WORD);

    // Row slot of a read, centre row is 1
    localparam logic [1:0] SLOT_ABOVE = 2'd0;
    localparam logic [1:0] SLOT_BELOW = 2'd2;

    ////////////////////
    // Types
    ////////////////////
    typedef logic signed [PIX_W-1:0] pixel_t;

    // Pixel 0 is leftmost, at the low byte
    typedef logic [SRAM_W-1:0] sram_word_t;

    typedef struct packed {
        logic [DIM_W-1:0] height;
        logic [DIM_W-1:0] width;
        logic [DIM_W-1:0] channel;
    } geom_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] slot;
        logic       pad;
        logic       col_end;
        logic       run_end;
    } load_t;

    // Tap index is 3 * window row + window column
    typedef pixel_t [TAPS-1:0] window_t;

    typedef struct packed {
        logic [TAPS-1:0] valid;
        window_t         taps;
        logic            last;
    } feed_t;

    function automatic pixel_t pix_at(input sram_word_t w, input logic [COL_W-1:0] p);
        return w[p*PIX_W +: PIX_W];
    endfunction

endpackage

/* src/delay_line.sv */
`timescale 1ns/100ps

module delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic i_clk,
    input  logic i_rst,
    input  T     i_d,
    output T     o_q
);

    if (DEPTH == 0) begin : g_pass
        assign o_q = i_d;
    end else begin : g_chain
        T stage [DEPTH];

        always_ff @(posedge i_clk) begin
            if (i_rst) begin
                for (int i = 0; i < DEPTH; i++) begin
                    stage[i] <= '0;
                end
            end else begin
                stage[0] <= i_d;
                for (int i = 1; i < DEPTH; i++) begin
                    stage[i] <= stage[i-1];
                end
            end
        end

        assign o_q = stage[DEPTH-1];
    end

endmodule

/* src/tap_skew.sv */
`timescale 1ns/100ps

module tap_skew (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  conv_feed_pkg::window_t    i_win,
    input  logic                      i_win_valid,
    input  logic                      i_win_last,
    output conv_feed_pkg::feed_t      o_feed
);

    localparam int TAPS = conv_feed_pkg::TAPS;

    conv_feed_pkg::window_t taps_d;
    logic [TAPS-1:0]        valid_d;
    logic                   last_d;

    // Tap k and its strobe are held back k cycles
    for (genvar k = 0; k < TAPS; k++) begin : g_tap
        delay_line #(
            .T     (conv_feed_pkg::pixel_t),
            .DEPTH (k)
        ) u_pix (
            .i_clk (i_clk),
            .i_rst (i_rst),
            .i_d   (i_win[k]),
            .o_q   (taps_d[k])
        );

        delay_line #(
            .T     (logic),
            .DEPTH (k)
        ) u_stb (
            .i_clk (i_clk),
            .i_rst (i_rst),
            .i_d   (i_win_valid),
            .o_q   (valid_d[k])
        );
    end

    // Last travels with the final tap
    delay_line #(
        .T     (logic),
        .DEPTH (TAPS - 1)
    ) u_last (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_d   (i_win_last),
        .o_q   (last_d)
    );

    assign o_feed = '{valid: valid_d, taps: taps_d, last: last_d};

endmodule

/* src/window_builder.sv */
`timescale 1ns/100ps

module window_builder (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  conv_feed_pkg::load_t          i_tag,
    input  conv_feed_pkg::sram_word_t     i_rd_data,
    output conv_feed_pkg::window_t        o_win,
    output logic                          o_win_valid,
    output logic                          o_win_last
);

    localparam int ROWS  = conv_feed_pkg::WIN_ROWS;
    localparam int COL_W = conv_feed_pkg::COL_W;
    localparam logic [COL_W-1:0] X_LAST = COL_W'(conv_feed_pkg::PIX_PER_WORD - 1);

    conv_feed_pkg::sram_word_t cur  [ROWS];
    conv_feed_pkg::sram_word_t nxt  [ROWS];
    conv_feed_pkg::pixel_t     left [ROWS];
    conv_feed_pkg::window_t    win_next;

    logic             running;
    logic             start_pend;
    logic [COL_W-1:0] x;
    logic             nxt_col_end;
    logic             nxt_run_end;
    logic             cur_col_end;
    logic             cur_run_end;
    logic             shift;

    // Move next into current at row start and after each eighth window
    assign shift = start_pend || (running && x == X_LAST);

    ////////////////////
    // Window select
    ////////////////////
    always_comb begin
        win_next = '0;
        for (int i = 0; i < ROWS; i++) begin
            if (x == '0) begin
                win_next[ROWS*i] = left[i];
            end else begin
                win_next[ROWS*i] = conv_feed_pkg::pix_at(cur[i], x - 1'b1);
            end

            win_next[ROWS*i+1] = conv_feed_pkg::pix_at(cur[i], x);

            // Right neighbor comes from the next word, zero past the edge
            if (x != X_LAST) begin
                win_next[ROWS*i+2] = conv_feed_pkg::pix_at(cur[i], x + 1'b1);
            end else if (!cur_col_end) begin
                win_next[ROWS*i+2] = conv_feed_pkg::pix_at(nxt[i], '0);
            end
        end
    end

    ////////////////////
    // Control
    ////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            running     <= 1'b0;
            start_pend  <= 1'b0;
            x           <= '0;
            nxt_col_end <= 1'b0;
            nxt_run_end <= 1'b0;
            cur_col_end <= 1'b0;
            cur_run_end <= 1'b0;
            o_win_valid <= 1'b0;
            o_win_last  <= 1'b0;
        end else begin
            // Last row of a prefetch arrives while idle
            start_pend  <= i_tag.valid && i_tag.slot == conv_feed_pkg::SLOT_BELOW && !running;
            o_win_valid <= running;
            o_win_last  <= running && x == X_LAST && cur_run_end;

            if (i_tag.valid) begin
                nxt_col_end <= i_tag.col_end;
                nxt_run_end <= i_tag.run_end;
            end

            if (start_pend) begin
                running     <= 1'b1;
                x           <= '0;
                cur_col_end <= nxt_col_end;
                cur_run_end <= nxt_run_end;
            end else if (running) begin
                x <= x + 1'b1;
                if (x == X_LAST) begin
                    cur_col_end <= nxt_col_end;
                    cur_run_end <= nxt_run_end;
                    if (cur_col_end) begin
                        running <= 1'b0;
                    end
                end
            end
        end
    end

    ////////////////////
    // Word buffer
    ////////////////////
    always_ff @(posedge i_clk) begin
        if (i_tag.valid) begin
            nxt[i_tag.slot] <= i_tag.pad ? '0 : i_rd_data;
        end
        if (shift) begin
            for (int i = 0; i < ROWS; i++) begin
                cur[i] <= nxt[i];
                // Left neighbor is zero at the start of a row
                if (start_pend || cur_col_end) begin
                    left[i] <= '0;
                end else begin
                    left[i] <= conv_feed_pkg::pix_at(cur[i], X_LAST);
                end
            end
        end
        o_win <= win_next;
    end

endmodule

/* src/addr_sequencer.sv */
`timescale 1ns/100ps

module addr_sequencer #(
    parameter int ADDR_W = 16
) (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_start,
    input  conv_feed_pkg::geom_t         i_geom,
    input  logic                         i_done,
    output logic                         o_rd_en,
    output logic [ADDR_W-1:0]            o_rd_addr,
    output conv_feed_pkg::load_t         o_tag,
    output logic                         o_busy
);

    localparam int CYC_W = conv_feed_pkg::COL_W;
    localparam int DIM_W = conv_feed_pkg::DIM_W;
    localparam logic [CYC_W-1:0] CYC_LAST = CYC_W'(conv_feed_pkg::PIX_PER_WORD - 1);
    localparam logic [CYC_W-1:0] PRE_LAST = CYC_W'(conv_feed_pkg::WIN_ROWS - 1);

    conv_feed_pkg::geom_t geom;
    logic                 busy;
    logic                 active;
    logic                 prefetch;
    logic [CYC_W-1:0]     cyc;
    logic [DIM_W-1:0]     row;
    logic [DIM_W-1:0]     col;
    logic [ADDR_W-1:0]    row_addr;
    logic [3*DIM_W-1:0]   chan_base;
    logic [DIM_W-1:0]     fetch_col;
    logic [1:0]           slot;
    logic [ADDR_W-1:0]    slot_addr;
    logic                 last_col;
    logic                 last_row;
    logic                 fetch;
    logic                 pad;
    logic                 accept;

    // Channel base, only sampled at start
    assign chan_base = i_geom.channel * i_geom.height * i_geom.width;

    assign accept   = i_start && !o_busy;
    assign last_col = (col == geom.width - 1'b1);
    assign last_row = (row == geom.height - 1'b1);
    assign slot     = cyc[1:0];

    // Prefetch loads column 0, a column phase loads the next one
    assign fetch_col = prefetch ? '0 : col + 1'b1;
    assign fetch     = active && (prefetch || (cyc <= PRE_LAST && !last_col));

    assign pad = (slot == conv_feed_pkg::SLOT_ABOVE && row == '0) ||
                 (slot == conv_feed_pkg::SLOT_BELOW && last_row);

    always_comb begin
        case (slot)
            conv_feed_pkg::SLOT_ABOVE: slot_addr = row_addr - ADDR_W'(geom.width);
            conv_feed_pkg::SLOT_BELOW: slot_addr = row_addr + ADDR_W'(geom.width);
            default:                   slot_addr = row_addr;
        endcase
    end

    assign o_rd_addr = slot_addr + ADDR_W'(fetch_col);
    assign o_rd_en   = fetch && !pad;
    assign o_busy    = busy && !i_done;

    ////////////////////
    // Control
    ////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            busy     <= 1'b0;
            active   <= 1'b0;
            prefetch <= 1'b0;
            cyc      <= '0;
            row      <= '0;
            col      <= '0;
            o_tag    <= '0;
        end else begin
            // Tag lines up with the read data one cycle later
            o_tag.valid   <= fetch;
            o_tag.slot    <= slot;
            o_tag.pad     <= pad;
            o_tag.col_end <= (fetch_col == geom.width - 1'b1);
            o_tag.run_end <= (fetch_col == geom.width - 1'b1) && last_row;

            if (accept) begin
                busy     <= 1'b1;
                active   <= 1'b1;
                prefetch <= 1'b1;
                cyc      <= '0;
                row      <= '0;
                col      <= '0;
            end else begin
                if (i_done) begin
                    busy <= 1'b0;
                end
                if (active) begin
                    if (prefetch) begin
                        if (cyc == PRE_LAST) begin
                            prefetch <= 1'b0;
                            cyc      <= '0;
                        end else begin
                            cyc <= cyc + 1'b1;
                        end
                    end else if (cyc == CYC_LAST) begin
                        cyc <= '0;
                        if (!last_col) begin
                            col <= col + 1'b1;
                        end else if (last_row) begin
                            active <= 1'b0;
                        end else begin
                            row      <= row + 1'b1;
                            col      <= '0;
                            prefetch <= 1'b1;
                        end
                    end else begin
                        cyc <= cyc + 1'b1;
                    end
                end
            end
        end
    end

    // Geometry and running row address
    always_ff @(posedge i_clk) begin
        if (accept) begin
            geom     <= i_geom;
            row_addr <= ADDR_W'(chan_base);
        end else if (active && !prefetch && cyc == CYC_LAST && last_col) begin
            row_addr <= row_addr + ADDR_W'(geom.width);
        end
    end

endmodule

/* src/conv_input_feeder.sv */
`timescale 1ns/100ps

module conv_input_feeder #(
    parameter int ADDR_W = 16
) (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_start,
    input  conv_feed_pkg::geom_t          i_geom,
    output logic                          o_rd_en,
    output logic [ADDR_W-1:0]             o_rd_addr,
    input  conv_feed_pkg::sram_word_t     i_rd_data,
    output conv_feed_pkg::feed_t          o_feed,
    output logic                          o_busy,
    output logic                          o_done
);

    conv_feed_pkg::load_t   tag;
    conv_feed_pkg::window_t win;
    logic                   win_valid;
    logic                   win_last;

    addr_sequencer #(
        .ADDR_W (ADDR_W)
    ) u_seq (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_start   (i_start),
        .i_geom    (i_geom),
        .i_done    (o_done),
        .o_rd_en   (o_rd_en),
        .o_rd_addr (o_rd_addr),
        .o_tag     (tag),
        .o_busy    (o_busy)
    );

    window_builder u_win (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_tag       (tag),
        .i_rd_data   (i_rd_data),
        .o_win       (win),
        .o_win_valid (win_valid),
        .o_win_last  (win_last)
    );

    tap_skew u_skew (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_win       (win),
        .i_win_valid (win_valid),
        .i_win_last  (win_last),
        .o_feed      (o_feed)
    );

    // Done one cycle after the final tap, also drops busy
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_done <= 1'b0;
        end else begin
            o_done <= o_feed.last;
        end
    end

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

/* tb/conv_input_feeder_props.sv */
`timescale 1ns/100ps

module conv_input_feeder_props (
    input logic                 i_clk,
    input logic                 i_rst,
    input logic                 i_rd_en,
    input logic                 i_busy,
    input conv_feed_pkg::feed_t i_feed,
    input logic                 i_done
);

    localparam int TAPS = conv_feed_pkg::TAPS;

    // Each strobe trails the one before it by a cycle
    for (genvar k = 1; k < TAPS; k++) begin : g_stagger
        a_stagger: assert property (@(posedge i_clk) disable iff (i_rst)
            i_feed.valid[k] == $past(i_feed.valid[k-1]))
            else $error("strobe %0d out of step with strobe %0d", k, k - 1);
    end

    a_done_after_last: assert property (@(posedge i_clk) disable iff (i_rst)
        i_feed.last |=> i_done)
        else $error("no done pulse after the final tap");

    a_done_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        i_done |=> !i_done)
        else $error("done held longer than one cycle");

    a_read_busy: assert property (@(posedge i_clk) disable iff (i_rst)
        i_rd_en |-> i_busy)
        else $error("SRAM read while not busy");

endmodule

bind conv_input_feeder conv_input_feeder_props u_props (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_rd_en (o_rd_en),
    .i_busy  (o_busy),
    .i_feed  (o_feed),
    .i_done  (o_done)
);

/* tb/conv_input_feeder_tb.sv */
`timescale 1ns/100ps

module conv_input_feeder_tb;

    localparam int ADDR_W    = 16;
    localparam int MEM_WORDS = 64;
    localparam int TAPS      = conv_feed_pkg::TAPS;
    localparam int PPW       = conv_feed_pkg::PIX_PER_WORD;
    localparam int PIX_W     = conv_feed_pkg::PIX_W;
    localparam int MARGIN    = 200;

    localparam conv_feed_pkg::geom_t G_SMALL = '{height: 8'd3, width: 8'd1, channel: 8'd0};
    localparam conv_feed_pkg::geom_t G_MID   = '{height: 8'd5, width: 8'd2, channel: 8'd2};
    localparam conv_feed_pkg::geom_t G_WIDE  = '{height: 8'd4, width: 8'd3, channel: 8'd1};
    localparam conv_feed_pkg::geom_t G_PAIR  = '{height: 8'd3, width: 8'd2, channel: 8'd1};

    logic                      clk;
    logic                      rst;
    logic                      start;
    conv_feed_pkg::geom_t      geom;
    logic                      rd_en;
    logic [ADDR_W-1:0]         rd_addr;
    conv_feed_pkg::sram_word_t rd_data = '0;
    conv_feed_pkg::feed_t      feed;
    logic                      busy;
    logic                      done;

    conv_feed_pkg::sram_word_t mem [MEM_WORDS];
    conv_feed_pkg::geom_t      run_geom = '0;
    int                        total = 0;
    int                        win_cnt [TAPS];
    int                        tap0_cyc [$];
    int                        exp_addr [$];
    int                        cyc = 0;
    int                        errors = 0;
    int                        checks = 0;
    int                        tests_run = 0;
    int                        tests_failed = 0;

    tb_clock #(.PERIOD_NS(100)) u_clock (.o_clk(clk));

    conv_input_feeder #(.ADDR_W(ADDR_W)) DUT (
        .i_clk     (clk),
        .i_rst     (rst),
        .i_start   (start),
        .i_geom    (geom),
        .o_rd_en   (rd_en),
        .o_rd_addr (rd_addr),
        .i_rd_data (rd_data),
        .o_feed    (feed),
        .o_busy    (busy),
        .o_done    (done)
    );

    ////////////////////
    // Helpers
    ////////////////////
    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int run_budget(input conv_feed_pkg::geom_t g);
        return 12 * g.height * g.width * PPW;
    endfunction

    // Tap k of window n, zero outside the map
    function automatic conv_feed_pkg::pixel_t ref_tap(input conv_feed_pkg::geom_t g,
                                                      input int n, input int k);
        int h;
        int w;
        int pr;
        int px;
        int addr;
        h  = g.height;
        w  = g.width;
        pr = n / (w * PPW) - 1 + k / 3;
        px = n % (w * PPW) - 1 + k % 3;
        if (pr < 0 || pr >= h || px < 0 || px >= w * PPW) begin
            return '0;
        end
        addr = int'(g.channel) * h * w + pr * w + px / PPW;
        return mem[addr][(px % PPW) * PIX_W +: PIX_W];
    endfunction

    task automatic fill_sram();
        logic [15:0] s;
        s = 16'd55;
        for (int a = 0; a < MEM_WORDS; a++) begin
            for (int b = 0; b < conv_feed_pkg::SRAM_W; b++) begin
                s = lfsr_next(s);
                mem[a][b] = s[0];
            end
        end
    endtask

    // Column by column, rows above, centre and below, padded rows skipped
    task automatic plan_reads(input conv_feed_pkg::geom_t g);
        int h;
        int w;
        h = g.height;
        w = g.width;
        exp_addr.delete();
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) begin
                for (int dr = -1; dr <= 1; dr++) begin
                    if (r + dr >= 0 && r + dr < h) begin
                        exp_addr.push_back(int'(g.channel) * h * w + (r + dr) * w + c);
                    end
                end
            end
        end
    endtask

    task automatic check_equal(input string name, input longint got, input longint exp);
        checks++;
        assert (got == exp) else begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cond(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            $display("Error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic idle_check(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_equal("o_busy", busy, 0);
            check_equal("o_done", done, 0);
            check_equal("o_rd_en", rd_en, 0);
            check_equal("o_feed.valid", feed.valid, 0);
        end
    endtask

    // Optionally pokes start while busy, returns in the o_done cycle
    task automatic run_feed(input conv_feed_pkg::geom_t g, input bit poke);
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        @(posedge clk);
        run_geom = g;
        total    = g.height * g.width * PPW;
        tap0_cyc.delete();
        foreach (win_cnt[k]) begin
            win_cnt[k] = 0;
        end
        plan_reads(g);
        geom  <= g;
        start <= 1'b1;
        while (!seen && n < run_budget(g)) begin
            @(posedge clk);
            start <= poke && n == 20;
            @(negedge clk);
            n++;
            seen = done;
            if (n == 1) begin
                check_cond(busy, "o_busy did not rise after the start strobe");
            end
        end
        check_cond(seen, "run timed out waiting for o_done");
        check_equal("o_busy", busy, 0);
        check_equal("reads still expected", exp_addr.size(), 0);
        for (int k = 0; k < TAPS; k++) begin
            check_equal($sformatf("windows on tap %0d", k), win_cnt[k], total);
        end
    endtask

    ////////////////////
    // SRAM and monitors
    ////////////////////
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (rd_en) begin
            rd_data <= mem[rd_addr % MEM_WORDS];
        end
    end

    always @(negedge clk) begin
        int exp_a;
        if (rd_en) begin
            check_cond(exp_addr.size() > 0, "SRAM read with no read expected");
            if (exp_addr.size() > 0) begin
                exp_a = exp_addr.pop_front();
                check_equal("o_rd_addr", rd_addr, exp_a);
            end
        end
    end

    always @(negedge clk) begin
        bit last_exp;
        last_exp = feed.valid[TAPS-1] && win_cnt[TAPS-1] == total - 1;
        for (int k = 0; k < TAPS; k++) begin
            if (feed.valid[k]) begin
                if (k == 0) begin
                    tap0_cyc.push_back(cyc);
                end
                if (win_cnt[k] >= total || win_cnt[k] >= tap0_cyc.size()) begin
                    check_cond(1'b0, $sformatf("tap %0d strobed with no window due", k));
                end else begin
                    check_equal($sformatf("delay of tap %0d", k),
                                cyc - tap0_cyc[win_cnt[k]], k);
                    check_equal($sformatf("o_feed.taps[%0d]", k), feed.taps[k],
                                ref_tap(run_geom, win_cnt[k], k));
                end
                win_cnt[k]++;
            end
        end
        if (feed.valid[TAPS-1] || feed.last) begin
            check_equal("o_feed.last", feed.last, last_exp);
        end
    end

    ////////////////////
    // Tests
    ////////////////////
    initial begin
        int e;
        rst   = 1'b1;
        start = 1'b0;
        geom  = '0;
        fill_sram();
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        e = errors;
        idle_check(20);
        report_test("1 reset and idle", e);

        e = errors;
        run_feed(G_SMALL, 1'b0);
        idle_check(5);
        report_test("2 8x3 map, channel 0", e);

        e = errors;
        run_feed(G_MID, 1'b0);
        idle_check(5);
        report_test("3 16x5 map, channel 2", e);

        e = errors;
        run_feed(G_WIDE, 1'b0);
        idle_check(5);
        report_test("4 tap stagger on 24x4 map", e);

        e = errors;
        run_feed(G_PAIR, 1'b1);
        run_feed(G_PAIR, 1'b0);
        idle_check(10);
        report_test("5 start while busy, back to back runs", e);

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        int limit;
        limit = run_budget(G_SMALL) + run_budget(G_MID) + run_budget(G_WIDE) +
                2 * run_budget(G_PAIR) + MARGIN;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run stopped", limit);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* sim.f */
src/conv_feed_pkg.sv
src/delay_line.sv
src/tap_skew.sv
src/window_builder.sv
src/addr_sequencer.sv
src/conv_input_feeder.sv
tb/tb_clock.sv
tb/conv_input_feeder_props.sv
tb/conv_input_feeder_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the feeder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module conv_input_feeder_tb -Mdir obj_dir -o sim_feed
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_feed)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1
